// ==== Bender.yml ====
package:
  name: mips_lite

sources:
  - hw/mips_pkg.sv
  - hw/fetch_stage.sv
  - hw/decode_stage.sv
  - hw/execute_stage.sv
  - hw/memory_stage.sv
  - hw/mips_top.sv
  - target: test
    files:
      - verif/tb_mips_top.sv

// ==== hw/decode_stage.sv ====
module decode_stage (
    input  logic              i_clock,
    input  logic              i_rst,
    input  mips_pkg::if_id_t  i_if_id,
    input  mips_pkg::mem_wb_t i_mem_wb,
    output mips_pkg::id_ex_t  o_id_ex,
    output logic              o_branch_taken,
    output mips_pkg::word_t   o_branch_target
);
    import mips_pkg::*;

    word_t    regs [32];
    word_t    read_a;
    word_t    read_b;
    word_t    imm_ext;
    reg_idx_t dest_idx;
    id_ex_t   id_ex_next;

    ////////////////////////////////////////
    // Register file
    ////////////////////////////////////////

    // r0 reads as zero, a same-cycle write is passed through
    function automatic word_t read_reg(reg_idx_t idx);
        word_t value;
        if (idx == '0) begin
            value = '0;
        end else if (i_mem_wb.reg_write && (i_mem_wb.dest == idx)) begin
            value = i_mem_wb.result;
        end else begin
            value = regs[idx];
        end
        return value;
    endfunction

    always_ff @(posedge i_clock) begin
        if (i_mem_wb.reg_write && (i_mem_wb.dest != '0)) begin
            regs[i_mem_wb.dest] <= i_mem_wb.result;
        end
    end

    always_comb begin
        read_a = read_reg(i_if_id.instr.rtype.rs);
        read_b = read_reg(i_if_id.instr.rtype.rt);
    end

    assign imm_ext = {{16{i_if_id.instr.itype.imm[15]}}, i_if_id.instr.itype.imm};

    ////////////////////////////////////////
    // Control decode
    ////////////////////////////////////////

    always_comb begin
        id_ex_next        = '0;
        id_ex_next.read_a = read_a;
        id_ex_next.read_b = read_b;
        id_ex_next.imm    = imm_ext;
        id_ex_next.rt     = i_if_id.instr.rtype.rt;
        id_ex_next.rd     = i_if_id.instr.rtype.rd;
        id_ex_next.alu_op = ALU_ADD;

        case (i_if_id.instr.itype.opcode)
            OP_RTYPE: begin
                id_ex_next.reg_write = 1'b1;
                case (i_if_id.instr.rtype.funct)
                    FN_ADDU: id_ex_next.alu_op = ALU_ADD;
                    FN_SUBU: id_ex_next.alu_op = ALU_SUB;
                    FN_AND:  id_ex_next.alu_op = ALU_AND;
                    FN_OR:   id_ex_next.alu_op = ALU_OR;
                    FN_SLT:  id_ex_next.alu_op = ALU_SLT;
                    // Includes the all-zero no-op
                    default: id_ex_next.reg_write = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                id_ex_next.use_imm    = 1'b1;
                id_ex_next.dest_is_rt = 1'b1;
                id_ex_next.reg_write  = 1'b1;
            end
            OP_LW: begin
                id_ex_next.use_imm    = 1'b1;
                id_ex_next.dest_is_rt = 1'b1;
                id_ex_next.mem_read   = 1'b1;
                id_ex_next.reg_write  = 1'b1;
            end
            OP_SW: begin
                id_ex_next.use_imm   = 1'b1;
                id_ex_next.mem_write = 1'b1;
            end
            // BEQ finishes here, it travels on as a bubble
            default: begin
                id_ex_next.alu_op = ALU_ADD;
            end
        endcase

        // No writeback is ever raised for r0
        dest_idx = id_ex_next.dest_is_rt ? id_ex_next.rt : id_ex_next.rd;
        if (dest_idx == '0) begin
            id_ex_next.reg_write = 1'b0;
        end
    end

    // Branch resolved here, one delay slot
    assign o_branch_taken  = (i_if_id.instr.itype.opcode == OP_BEQ) && (read_a == read_b);
    assign o_branch_target = i_if_id.pc_plus4 + {imm_ext[DATA_WIDTH-3:0], 2'b00};

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            o_id_ex <= '0;
        end else begin
            o_id_ex <= id_ex_next;
        end
    end

endmodule

// ==== hw/execute_stage.sv ====
module execute_stage (
    input  logic              i_clock,
    input  logic              i_rst,
    input  mips_pkg::id_ex_t  i_id_ex,
    output mips_pkg::ex_mem_t o_ex_mem
);
    import mips_pkg::*;

    word_t    alu_b;
    word_t    alu_result;
    reg_idx_t dest;

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////

    assign alu_b = i_id_ex.use_imm ? i_id_ex.imm : i_id_ex.read_b;

    always_comb begin
        case (i_id_ex.alu_op)
            ALU_ADD: alu_result = i_id_ex.read_a + alu_b;
            ALU_SUB: alu_result = i_id_ex.read_a - alu_b;
            ALU_AND: alu_result = i_id_ex.read_a & alu_b;
            ALU_OR:  alu_result = i_id_ex.read_a | alu_b;
            // Signed compare
            ALU_SLT: begin
                alu_result = ($signed(i_id_ex.read_a) < $signed(alu_b)) ? 32'd1 : 32'd0;
            end
            default: alu_result = '0;
        endcase
    end

    // I-type writes rt, R-type writes rd
    assign dest = i_id_ex.dest_is_rt ? i_id_ex.rt : i_id_ex.rd;

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            o_ex_mem <= '0;
        end else begin
            o_ex_mem.alu_result <= alu_result;
            o_ex_mem.store_data <= i_id_ex.read_b;
            o_ex_mem.dest       <= dest;
            o_ex_mem.mem_read   <= i_id_ex.mem_read;
            o_ex_mem.mem_write  <= i_id_ex.mem_write;
            o_ex_mem.reg_write  <= i_id_ex.reg_write;
        end
    end

endmodule

// ==== hw/fetch_stage.sv ====
module fetch_stage (
    input  logic             i_clock,
    input  logic             i_rst,
    input  logic             i_branch_taken,
    input  mips_pkg::word_t  i_branch_target,
    output mips_pkg::if_id_t o_if_id
);
    import mips_pkg::*;

    word_t                          pc;
    word_t                          pc_plus4;
    logic [$clog2(IMEM_DEPTH)-1:0]  imem_index;

    // Instruction ROM
    word_t imem [IMEM_DEPTH];

    initial begin
        $readmemh(IMEM_FILE, imem);
    end

    assign pc_plus4   = pc + 32'd4;
    // Word address, byte offset dropped
    assign imem_index = pc[$clog2(IMEM_DEPTH)+1:2];

    ////////////////////////////////////////
    // PC and IF/ID register
    ////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            pc      <= '0;
            o_if_id <= '0;
        end else begin
            o_if_id.pc_plus4 <= pc_plus4;
            o_if_id.instr    <= imem[imem_index];
            // Word fetched this cycle is the delay slot when a branch is taken
            if (i_branch_taken) begin
                pc <= i_branch_target;
            end else begin
                pc <= pc_plus4;
            end
        end
    end

endmodule

// ==== hw/memory_stage.sv ====
module memory_stage (
    input  logic              i_clock,
    input  logic              i_rst,
    input  mips_pkg::ex_mem_t i_ex_mem,
    output mips_pkg::mem_wb_t o_mem_wb
);
    import mips_pkg::*;

    logic [$clog2(DMEM_DEPTH)-1:0] dmem_index;
    word_t                         load_data;

    // Data RAM
    word_t dmem [DMEM_DEPTH];

    // Word addressing, low address bits only
    assign dmem_index = i_ex_mem.alu_result[$clog2(DMEM_DEPTH)+1:2];

    // Asynchronous read
    assign load_data = dmem[dmem_index];

    always_ff @(posedge i_clock) begin
        if (i_ex_mem.mem_write) begin
            dmem[dmem_index] <= i_ex_mem.store_data;
        end
    end

    ////////////////////////////////////////
    // MEM/WB register
    ////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            o_mem_wb <= '0;
        end else begin
            o_mem_wb.result    <= i_ex_mem.mem_read ? load_data : i_ex_mem.alu_result;
            o_mem_wb.dest      <= i_ex_mem.dest;
            o_mem_wb.reg_write <= i_ex_mem.reg_write;
        end
    end

endmodule

// ==== hw/mips_pkg.sv ====
package mips_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////

    localparam int DATA_WIDTH = 32;
    localparam int IMEM_DEPTH = 64;
    localparam int DMEM_DEPTH = 64;

    // Program image, read once at elaboration
    localparam string IMEM_FILE = "program.hex";

    ////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] OP_BEQ   = 6'h04;

    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    // Internal ALU selects
    localparam logic [2:0] ALU_ADD = 3'd0;
    localparam logic [2:0] ALU_SUB = 3'd1;
    localparam logic [2:0] ALU_AND = 3'd2;
    localparam logic [2:0] ALU_OR  = 3'd3;
    localparam logic [2:0] ALU_SLT = 3'd4;

    ////////////////////////////////////////
    // Types
    ////////////////////////////////////////

    typedef logic [DATA_WIDTH-1:0] word_t;
    typedef logic [4:0]            reg_idx_t;

    typedef struct packed {
        logic [5:0] opcode;
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_idx_t    rs;
        reg_idx_t    rt;
        logic [15:0] imm;
    } i_fields_t;

    // Same word, two field layouts
    typedef union packed {
        r_fields_t rtype;
        i_fields_t itype;
    } instr_u;

    // Pipeline registers
    typedef struct packed {
        word_t  pc_plus4;
        instr_u instr;
    } if_id_t;

    typedef struct packed {
        word_t      read_a;
        word_t      read_b;
        word_t      imm;
        reg_idx_t   rt;
        reg_idx_t   rd;
        logic [2:0] alu_op;
        logic       use_imm;
        logic       dest_is_rt;
        logic       mem_read;
        logic       mem_write;
        logic       reg_write;
    } id_ex_t;

    typedef struct packed {
        word_t    alu_result;
        word_t    store_data;
        reg_idx_t dest;
        logic     mem_read;
        logic     mem_write;
        logic     reg_write;
    } ex_mem_t;

    typedef struct packed {
        word_t    result;
        reg_idx_t dest;
        logic     reg_write;
    } mem_wb_t;

endpackage

// ==== hw/mips_top.sv ====
module mips_top (
    input  logic               i_clock,
    input  logic               i_rst,
    output logic               o_wb_valid,
    output mips_pkg::reg_idx_t o_wb_dest,
    output mips_pkg::word_t    o_result_wb
);
    import mips_pkg::*;

    // Stage to stage registers
    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;

    // Decode back to fetch
    logic  branch_taken;
    word_t branch_target;

    ////////////////////////////////////////
    // Stages
    ////////////////////////////////////////

    fetch_stage fetch_stage_inst (
        .i_clock         (i_clock),
        .i_rst           (i_rst),
        .i_branch_taken  (branch_taken),
        .i_branch_target (branch_target),
        .o_if_id         (if_id)
    );

    decode_stage decode_stage_inst (
        .i_clock         (i_clock),
        .i_rst           (i_rst),
        .i_if_id         (if_id),
        .i_mem_wb        (mem_wb),
        .o_id_ex         (id_ex),
        .o_branch_taken  (branch_taken),
        .o_branch_target (branch_target)
    );

    execute_stage execute_stage_inst (
        .i_clock  (i_clock),
        .i_rst    (i_rst),
        .i_id_ex  (id_ex),
        .o_ex_mem (ex_mem)
    );

    memory_stage memory_stage_inst (
        .i_clock  (i_clock),
        .i_rst    (i_rst),
        .i_ex_mem (ex_mem),
        .o_mem_wb (mem_wb)
    );

    // Writeback port seen from outside, r0 never flagged
    assign o_wb_valid  = mem_wb.reg_write;
    assign o_wb_dest   = mem_wb.dest;
    assign o_result_wb = mem_wb.result;

endmodule

// ==== mips_lite.f ====
hw/mips_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/mips_top.sv
verif/tb_mips_top.sv

// ==== verif/program.hex ====
// One 32-bit instruction word per line in hex, starting at word address 0
// The assembly for each word follows it as a comment
24010007  // 00: addiu r1, r0, 7
2402fffd  // 01: addiu r2, r0, -3
2403000c  // 02: addiu r3, r0, 12
24000005  // 03: addiu r0, r0, 5       dropped, no writeback
00222021  // 04: addu  r4, r1, r2
00412823  // 05: subu  r5, r2, r1
00233024  // 06: and   r6, r1, r3
00233825  // 07: or    r7, r1, r3
0041402a  // 08: slt   r8, r2, r1      signed, -3 < 7
0022482a  // 09: slt   r9, r1, r2
00075021  // 10: addu  r10, r0, r7
ac650008  // 11: sw    r5, 8(r3)       word address 5
8c0b0014  // 12: lw    r11, 20(r0)
10860003  // 13: beq   r4, r6, +3      taken, to word 17
240c0055  // 14: addiu r12, r0, 0x55   delay slot
240d0066  // 15: addiu r13, r0, 0x66   skipped
240e0077  // 16: addiu r14, r0, 0x77   skipped
10230002  // 17: beq   r1, r3, +2      not taken
240f0123  // 18: addiu r15, r0, 0x123
25700001  // 19: addiu r16, r11, 1
1000ffff  // 20: beq   r0, r0, -1      self loop
00000000  // 21: nop                   delay slot

// ==== verif/tb_mips_top.sv ====
module tb_mips_top;
    import mips_pkg::*;

    localparam int CLK_PERIOD  = 10;
    localparam int NUM_WB      = 14;
    localparam int FILL_CYCLES = 4;
    localparam int TAIL_CYCLES = 20;
    localparam int LIMIT       = NUM_WB * 8 + 40;

    // One expected register writeback
    typedef struct packed {
        reg_idx_t dest;
        word_t    value;
    } wb_entry_t;

    logic     clock = 1'b0;
    logic     rst;
    logic     wb_valid;
    reg_idx_t wb_dest;
    word_t    result_wb;

    wb_entry_t wb_table [NUM_WB];
    int        pass_count;
    int        fail_count;
    int        idx;
    int        cycle;
    bit        entry_ok;

    mips_top mips_top_inst (
        .i_clock     (clock),
        .i_rst       (rst),
        .o_wb_valid  (wb_valid),
        .o_wb_dest   (wb_dest),
        .o_result_wb (result_wb)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    ////////////////////////////////////////
    // Expected writebacks
    ////////////////////////////////////////

    task automatic set_entry(input int pos, input reg_idx_t dest, input word_t value);
        wb_table[pos].dest  = dest;
        wb_table[pos].value = value;
    endtask

    // Program order as worked out from program.hex
    task automatic fill_table();
        set_entry(0,  5'd1,  32'h0000_0007);
        set_entry(1,  5'd2,  32'hffff_fffd);  // -3 sign extended
        set_entry(2,  5'd3,  32'h0000_000c);
        set_entry(3,  5'd4,  32'h0000_0004);  // 7 + -3
        set_entry(4,  5'd5,  32'hffff_fff6);  // -3 - 7
        set_entry(5,  5'd6,  32'h0000_0004);  // 7 & 12
        set_entry(6,  5'd7,  32'h0000_000f);  // 7 | 12
        set_entry(7,  5'd8,  32'h0000_0001);
        set_entry(8,  5'd9,  32'h0000_0000);
        set_entry(9,  5'd10, 32'h0000_000f);  // r0 + r7
        set_entry(10, 5'd11, 32'hffff_fff6);  // loaded back from memory
        set_entry(11, 5'd12, 32'h0000_0055);  // delay slot of the taken branch
        set_entry(12, 5'd15, 32'h0000_0123);
        set_entry(13, 5'd16, 32'hffff_fff7);
    endtask

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    task automatic check_dest(input int pos, input reg_idx_t expected, input reg_idx_t actual);
        if (actual !== expected) begin
            $display("MISMATCH entry %0d o_wb_dest: expected 0x%02h, got 0x%02h",
                     pos, expected, actual);
            entry_ok = 1'b0;
        end
    endtask

    task automatic check_value(input int pos, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("MISMATCH entry %0d o_result_wb: expected 0x%08h, got 0x%08h",
                     pos, expected, actual);
            entry_ok = 1'b0;
        end
    endtask

    task automatic record_result(input string name);
        if (entry_ok) begin
            $display("PASS %s", name);
            pass_count++;
        end else begin
            $display("FAIL %s", name);
            fail_count++;
        end
    endtask

    initial begin
        rst        <= 1'b1;
        pass_count = 0;
        fail_count = 0;
        fill_table();

        // Valid must stay low through three reset edges
        entry_ok = 1'b1;
        for (cycle = 0; cycle < 3; cycle++) begin
            @(posedge clock);
            if (cycle == 2) begin
                rst <= 1'b0;
            end
            @(negedge clock);
            if (wb_valid !== 1'b0) begin
                $display("ERROR writeback valid is not low in reset cycle %0d", cycle);
                entry_ok = 1'b0;
            end
        end
        // Pipeline still filling
        for (cycle = 0; cycle < FILL_CYCLES; cycle++) begin
            @(posedge clock);
            if (wb_valid !== 1'b0) begin
                $display("ERROR writeback valid raised %0d cycles after reset", cycle);
                entry_ok = 1'b0;
            end
        end
        record_result("reset and pipeline fill");

        for (idx = 0; idx < NUM_WB; idx++) begin
            do begin
                @(posedge clock);
            end while (wb_valid !== 1'b1);
            entry_ok = 1'b1;
            check_dest(idx, wb_table[idx].dest, wb_dest);
            check_value(idx, wb_table[idx].value, result_wb);
            record_result($sformatf("entry %0d r%0d = 0x%08h",
                                    idx, wb_table[idx].dest, wb_table[idx].value));
        end

        // Nothing may write back once the self loop is reached
        entry_ok = 1'b1;
        repeat (TAIL_CYCLES) begin
            @(posedge clock);
            if (wb_valid !== 1'b0) begin
                $display("ERROR unexpected writeback to r%0d of 0x%08h after the last entry",
                         wb_dest, result_wb);
                entry_ok = 1'b0;
            end
        end
        record_result("no writeback after the program end");

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(LIMIT * CLK_PERIOD);
        $display("ERROR timeout, the run did not finish within %0d cycles", LIMIT);
        $display("Test failed");
        $finish;
    end

endmodule
